// File: fcs_crc32.sv
`default_nettype none
`timescale 1ns/10ps

`include "mac_frame_cfg.svh"

module fcs_crc32 import mac_frame_pkg::*; (
    input  wire logic       clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_init,         // restart for a new frame
    input  wire logic       i_update,       // fold i_data into the running crc
    input  wire tx_word_t   i_data,
    input  wire logic [3:0] i_nbytes,       // top bytes of i_data that count
    output logic [31:0]     o_fcs
);

    logic [31:0] crc_q;        // running crc, not complemented
    logic [31:0] crc_next;

    // byte-serial crc unrolled over one word, msb first
    always_comb begin
        crc_next = crc_q;
        for (int b = 0; b < `MAC_WORD_BYTES; b++) begin
            if (b < i_nbytes) begin
                crc_next = crc_next ^ {i_data[8*(`MAC_WORD_BYTES-b)-1 -: 8], 24'h000000};
                for (int k = 0; k < 8; k++) begin
                    if (crc_next[31]) begin
                        crc_next = (crc_next << 1) ^ `MAC_CRC_POLY;
                    end else begin
                        crc_next = crc_next << 1;
                    end
                end
            end
        end
    end

    // includes the word presented now
    assign o_fcs = ~crc_next;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc_q <= `MAC_CRC_INIT;
        end else if (i_init) begin
            crc_q <= `MAC_CRC_INIT;
        end else if (i_update) begin
            crc_q <= crc_next;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
mac_frame_pkg.sv
frame_builder.sv
fcs_crc32.sv
tx_sequencer.sv
mac_frame_gen.sv
tb_mac_frame_gen.sv

// File: frame_builder.sv
`default_nettype none
`timescale 1ns/10ps

`include "mac_frame_cfg.svh"

module frame_builder import mac_frame_pkg::*; (
    input  wire logic         clk,
    input  wire logic         i_rst_n,
    input  wire logic         i_load,          // capture a new frame
    input  wire logic         i_shift,         // advance to the next word
    input  wire frame_hdr_t   i_hdr,
    input  wire payload_t     i_payload,
    input  wire payload_len_t i_payload_len,
    input  wire logic         i_fixed_fill,
    output tx_word_t          o_word
);

    payload_len_t len_clamped;
    payload_t     pay_fmt;      // payload after fill and padding
    body_t        body_next;
    body_t        body_q;       // shift register, top bytes go out first

    // anything past the minimum frame is cut off
    assign len_clamped = (i_payload_len > payload_len_t'(`MAC_PAYLOAD_MAX)) ?
                         payload_len_t'(`MAC_PAYLOAD_MAX) : i_payload_len;

    always_comb begin
        for (int i = 0; i < `MAC_PAYLOAD_MAX; i++) begin
            if (i >= len_clamped) begin
                pay_fmt[i] = 8'h00;                // zero padding
            end else if (i_fixed_fill) begin
                pay_fmt[i] = `MAC_FILL_BYTE;
            end else begin
                pay_fmt[i] = i_payload[i];
            end
        end

        // header first, then payload and padding
        body_next[0:`MAC_HDR_BYTES-1]               = i_hdr;
        body_next[`MAC_HDR_BYTES:`MAC_BODY_BYTES-1] = pay_fmt;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            body_q <= '0;
        end else if (i_load) begin
            body_q <= body_next;
        end else if (i_shift) begin
            // move up one word, zeros come in at the tail
            body_q <= {body_q[`MAC_WORD_BYTES:`MAC_BODY_BYTES-1],
                       {`MAC_WORD_BYTES{8'h00}}};
        end
    end

    // last word holds bytes 56..59 and four zero bytes
    assign o_word = body_q[0:`MAC_WORD_BYTES-1];

endmodule

`default_nettype wire

// File: mac_frame_cfg.svh
`ifndef MAC_FRAME_CFG_SVH
`define MAC_FRAME_CFG_SVH

// frame geometry in bytes
`define MAC_WORD_BYTES   8
`define MAC_HDR_BYTES    14
`define MAC_PAYLOAD_MAX  46
`define MAC_BODY_BYTES   60

// words after the preamble, the last one is half body half fcs
`define MAC_BODY_WORDS   8

// seven preamble bytes then the start frame delimiter
`define MAC_PREAMBLE_SFD 64'h55555555555555D5

// crc-32, non reflected, msb first
`define MAC_CRC_POLY     32'h04C11DB7
`define MAC_CRC_INIT     32'hFFFFFFFF

// byte that replaces the payload in fixed-fill mode
`define MAC_FILL_BYTE    8'h55

`endif

// File: mac_frame_gen.sv
`default_nettype none
`timescale 1ns/10ps

module mac_frame_gen import mac_frame_pkg::*; (
    input  wire logic         clk,
    input  wire logic         i_rst_n,
    input  wire logic         i_start,
    input  wire frame_hdr_t   i_hdr,
    input  wire payload_t     i_payload,
    input  wire payload_len_t i_payload_len,
    input  wire logic         i_fixed_fill,     // payload replaced by fill byte
    output logic              o_valid,
    output tx_word_t          o_data,
    output logic              o_done
);

    logic        load;
    logic        shift;
    tx_word_t    body_word;
    logic        crc_init;
    logic        crc_update;
    tx_word_t    crc_word;
    logic [3:0]  crc_nbytes;
    logic [31:0] fcs;

    frame_builder u_frame_builder (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_load        (load),
        .i_shift       (shift),
        .i_hdr         (i_hdr),
        .i_payload     (i_payload),
        .i_payload_len (i_payload_len),
        .i_fixed_fill  (i_fixed_fill),
        .o_word        (body_word)
    );

    fcs_crc32 u_fcs_crc32 (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_init   (crc_init),
        .i_update (crc_update),
        .i_data   (crc_word),
        .i_nbytes (crc_nbytes),
        .o_fcs    (fcs)
    );

    tx_sequencer u_tx_sequencer (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_body_word  (body_word),
        .i_fcs        (fcs),
        .o_load       (load),
        .o_shift      (shift),
        .o_crc_init   (crc_init),
        .o_crc_update (crc_update),
        .o_crc_word   (crc_word),
        .o_crc_nbytes (crc_nbytes),
        .o_valid      (o_valid),
        .o_data       (o_data),
        .o_done       (o_done)
    );

endmodule

`default_nettype wire

// File: mac_frame_pkg.sv
`default_nettype none

`include "mac_frame_cfg.svh"

package mac_frame_pkg;

    // first field goes out first
    typedef struct packed {
        logic [47:0] dest_addr;
        logic [47:0] src_addr;
        logic [15:0] eth_type;     // ethertype or length
    } frame_hdr_t;

    // byte 0 is the top byte and the first one sent
    typedef logic [0:`MAC_PAYLOAD_MAX-1][7:0] payload_t;

    typedef logic [5:0] payload_len_t;    // 0..63, clamped to 46 inside

    // output word, first byte on the line in bits 63:56
    typedef logic [`MAC_WORD_BYTES*8-1:0] tx_word_t;

    // header + payload + padding, same byte order as payload_t
    typedef logic [0:`MAC_BODY_BYTES-1][7:0] body_t;

endpackage

`default_nettype wire

// File: tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// body bytes in line order: header, payload up to the length, zero pad
function automatic body_t build_body(frame_hdr_t hdr, payload_t pay,
                                     payload_len_t len, bit fill);
    body_t        body;
    logic [111:0] hdr_bits;
    int           n;
    hdr_bits = hdr;
    n = (len > `MAC_PAYLOAD_MAX) ? `MAC_PAYLOAD_MAX : int'(len);
    for (int i = 0; i < `MAC_HDR_BYTES; i++) begin
        body[i] = hdr_bits[111 - 8*i -: 8];   // dest first
    end
    for (int i = 0; i < `MAC_PAYLOAD_MAX; i++) begin
        if (i >= n) begin
            body[`MAC_HDR_BYTES + i] = 8'h00;
        end else begin
            body[`MAC_HDR_BYTES + i] = fill ? `MAC_FILL_BYTE : pay[i];
        end
    end
    return body;
endfunction

// bit at a time, msb of each byte first
function automatic logic [31:0] calc_fcs(body_t body);
    logic [31:0] crc;
    logic        fb;
    crc = `MAC_CRC_INIT;
    for (int i = 0; i < `MAC_BODY_BYTES; i++) begin
        for (int b = 7; b >= 0; b--) begin
            fb  = crc[31] ^ body[i][b];
            crc = {crc[30:0], 1'b0};
            if (fb) begin
                crc = crc ^ `MAC_CRC_POLY;
            end
        end
    end
    return ~crc;
endfunction

// word idx of the frame on the line, 0 is the preamble
function automatic tx_word_t line_word(body_t body, logic [31:0] fcs, int idx);
    logic [7:0] frame_bytes [0:63];
    tx_word_t   w;
    if (idx == 0) begin
        return `MAC_PREAMBLE_SFD;
    end
    for (int i = 0; i < `MAC_BODY_BYTES; i++) begin
        frame_bytes[i] = body[i];
    end
    for (int i = 0; i < 4; i++) begin
        frame_bytes[`MAC_BODY_BYTES + i] = fcs[31 - 8*i -: 8];   // fcs msb first
    end
    for (int j = 0; j < `MAC_WORD_BYTES; j++) begin
        w[63 - 8*j -: 8] = frame_bytes[8*(idx - 1) + j];
    end
    return w;
endfunction

`endif

// File: tb_mac_frame_gen.sv
`default_nettype none
`timescale 1ns/10ps

`include "mac_frame_cfg.svh"

module tb_mac_frame_gen import mac_frame_pkg::*; ();

    localparam int N_RANDOM = 200;
    localparam int N_FILL   = 50;
    localparam int N_TIMING = 10;
    localparam int N_BUSY   = 20;
    localparam int N_PAIRS  = 10;
    localparam int N_FRAMES = N_RANDOM + N_FILL + N_TIMING + N_BUSY + 2 * N_PAIRS;
    localparam int TIMEOUT_CYCLES = 12 * N_FRAMES + 100;

    logic         clk;
    logic         i_rst_n;
    logic         i_start;
    frame_hdr_t   i_hdr;
    payload_t     i_payload;
    payload_len_t i_payload_len;
    logic         i_fixed_fill;
    logic         o_valid;
    tx_word_t     o_data;
    logic         o_done;

    int unsigned cyc;             // rising edges so far
    int unsigned seed_val;
    int unsigned rnd_first;
    int unsigned checks;
    int unsigned errors;
    int unsigned tests_run;
    int unsigned tests_failed;
    int unsigned errors_at_start;
    tx_word_t    got_word[$];
    int unsigned got_word_cyc[$];
    int unsigned got_done_cyc[$];
    tx_word_t    exp_word[$];
    int unsigned exp_word_cyc[$];
    int unsigned exp_done_cyc[$];

    `include "tb_frame_model.svh"

    mac_frame_gen DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, frames did not finish in time", cyc);
            $display("TB FAILED");
            $finish;
        end
    end

    // outputs change on the rising edge, sample half a cycle later
    always @(negedge clk) begin
        if (o_valid) begin
            got_word.push_back(o_data);
            got_word_cyc.push_back(cyc);
        end
        if (o_done) begin
            got_done_cyc.push_back(cyc);
        end
    end

    task automatic randomize_inputs(input bit fill);
        logic [127:0] r;
        r = {$urandom, $urandom, $urandom, $urandom};
        i_hdr = r[111:0];
        for (int i = 0; i < `MAC_PAYLOAD_MAX; i++) begin
            i_payload[i] = 8'($urandom);
        end
        i_payload_len = 6'($urandom_range(63, 0));   // beyond 46 gets clamped
        i_fixed_fill  = fill;
    endtask

    // called on a falling edge, start is sampled at edge s
    task automatic launch_frame(input bit fill);
        int unsigned s;
        body_t       body;
        logic [31:0] fcs;
        s = cyc + 1;
        randomize_inputs(fill);
        i_start = 1'b1;
        body = build_body(i_hdr, i_payload, i_payload_len, fill);
        fcs  = calc_fcs(body);
        for (int i = 0; i <= `MAC_BODY_WORDS; i++) begin
            exp_word.push_back(line_word(body, fcs, i));
            exp_word_cyc.push_back(s + 1 + i);
        end
        exp_done_cyc.push_back(s + `MAC_BODY_WORDS + 2);
    endtask

    task automatic compare_frames(input string name);
        tx_word_t    w;
        int unsigned c;
        while (got_done_cyc.size() < exp_done_cyc.size()) begin
            @(posedge clk);
        end
        while (exp_word.size() > 0 && got_word.size() > 0) begin
            w = got_word.pop_front();
            c = got_word_cyc.pop_front();
            checks += 2;
            assert (w == exp_word[0]) else begin
                $display("Fail %s: word at cycle %0d expected %h actual %h",
                         name, c, exp_word[0], w);
                errors++;
            end
            assert (c == exp_word_cyc[0]) else begin
                $display("Fail %s: valid word cycle expected %0d actual %0d",
                         name, exp_word_cyc[0], c);
                errors++;
            end
            exp_word.delete(0);
            exp_word_cyc.delete(0);
        end
        assert (exp_word.size() == 0) else begin
            $display("%s: %0d words never came out of the DUT", name, exp_word.size());
            errors++;
            exp_word.delete();
            exp_word_cyc.delete();
        end
        while (exp_done_cyc.size() > 0) begin
            c = got_done_cyc.pop_front();
            checks++;
            assert (c == exp_done_cyc[0]) else begin
                $display("Fail %s: done cycle expected %0d actual %0d",
                         name, exp_done_cyc[0], c);
                errors++;
            end
            exp_done_cyc.delete(0);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // one frame at a time, optional idle gap before each start
    task automatic run_single(input string name, input int n, input bit fill,
                              input int max_gap);
        for (int f = 0; f < n; f++) begin
            repeat ($urandom_range(max_gap, 0)) @(negedge clk);
            @(negedge clk);
            launch_frame(fill);
            @(negedge clk);
            i_start = 1'b0;
            compare_frames(name);
        end
        finish_test(name);
    endtask

    initial begin
        cyc           = 0;
        checks        = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_at_start = 0;
        i_rst_n       = 1'b0;
        i_start       = 1'b0;
        i_hdr         = '0;
        i_payload     = '0;
        i_payload_len = '0;
        i_fixed_fill  = 1'b0;
        seed_val      = 32'h7771;
        rnd_first     = $urandom(seed_val);

        repeat (3) @(posedge clk);
        // first look is still inside reset, the second one after release
        repeat (2) begin
            @(negedge clk);
            checks++;
            assert (!o_valid && !o_done && o_data == '0) else begin
                $display("Fail reset_state: expected valid 0 done 0 data 0 actual %b %b %h",
                         o_valid, o_done, o_data);
                errors++;
            end
            i_rst_n = 1'b1;
        end
        finish_test("reset_state");

        run_single("random_frames", N_RANDOM, 1'b0, 0);
        run_single("fixed_fill", N_FILL, 1'b1, 0);
        run_single("timing", N_TIMING, 1'b0, 2);

        for (int f = 0; f < N_BUSY; f++) begin
            @(negedge clk);
            launch_frame(1'b0);
            for (int k = 1; k <= `MAC_BODY_WORDS + 1; k++) begin
                @(negedge clk);
                randomize_inputs(1'($urandom_range(1, 0)));
                i_start = (k == 5) ? 1'b1 : 1'($urandom_range(1, 0));
            end
            @(negedge clk);
            i_start = 1'b0;                    // done edge would accept it
            compare_frames("start_busy");
        end
        finish_test("start_busy");

        for (int p = 0; p < N_PAIRS; p++) begin
            @(negedge clk);
            launch_frame(1'($urandom_range(1, 0)));
            repeat (`MAC_BODY_WORDS + 1) begin
                @(negedge clk);
                i_start = 1'b0;
            end
            @(negedge clk);
            launch_frame(1'($urandom_range(1, 0)));   // sampled at the done edge
            @(negedge clk);
            i_start = 1'b0;
            compare_frames("back_to_back");
        end
        repeat (12) @(negedge clk);
        checks++;
        assert (got_word.size() == 0 && got_done_cyc.size() == 0) else begin
            $display("back_to_back: DUT sent %0d words and %0d done pulses with no start",
                     got_word.size(), got_done_cyc.size());
            errors++;
        end
        finish_test("back_to_back");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tx_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

`include "mac_frame_cfg.svh"

module tx_sequencer import mac_frame_pkg::*; (
    input  wire logic       clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_start,
    input  wire tx_word_t   i_body_word,    // current word from the builder
    input  wire logic [31:0] i_fcs,
    output logic            o_load,
    output logic            o_shift,
    output logic            o_crc_init,
    output logic            o_crc_update,
    output tx_word_t        o_crc_word,
    output logic [3:0]      o_crc_nbytes,
    output logic            o_valid,
    output tx_word_t        o_data,
    output logic            o_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_BODY,
        ST_DONE
    } state_t;

    state_t     state;
    logic [2:0] word_cnt;      // body word being sent, 0..7
    logic       accept;
    logic       last_word;
    logic       pre_last;

    // a start during a frame is dropped, the done cycle takes a new one
    assign accept    = i_start && (state == ST_IDLE || state == ST_DONE);
    assign last_word = (word_cnt == 3'(`MAC_BODY_WORDS - 1));
    assign pre_last  = (word_cnt == 3'(`MAC_BODY_WORDS - 2));

    // load and init land on the start edge so word 1 is ready in PREAMBLE
    assign o_load     = accept;
    assign o_crc_init = accept;

    // crc sees each body word one cycle before it is sent
    always_ff @(posedge clk) begin
        o_crc_word <= i_body_word;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= ST_IDLE;
            word_cnt     <= '0;
            o_shift      <= 1'b0;
            o_crc_update <= 1'b0;
            o_crc_nbytes <= '0;
            o_valid      <= 1'b0;
            o_data       <= '0;
            o_done       <= 1'b0;
        end else begin
            o_shift      <= 1'b0;
            o_crc_update <= 1'b0;
            o_valid      <= 1'b0;
            o_data       <= '0;
            o_done       <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state   <= ST_PREAMBLE;
                        o_shift <= 1'b1;            // word 2 behind word 1
                    end
                end
                ST_PREAMBLE: begin
                    o_valid      <= 1'b1;
                    o_data       <= `MAC_PREAMBLE_SFD;
                    o_shift      <= 1'b1;
                    o_crc_update <= 1'b1;           // word 1 into the crc
                    o_crc_nbytes <= 4'(`MAC_WORD_BYTES);
                    word_cnt     <= '0;
                    state        <= ST_BODY;
                end
                ST_BODY: begin
                    o_valid  <= 1'b1;
                    word_cnt <= word_cnt + 3'd1;
                    if (last_word) begin
                        // bytes 56..59 then the fcs
                        o_data <= {o_crc_word[63:32], i_fcs};
                        state  <= ST_DONE;
                    end else begin
                        o_data       <= o_crc_word;
                        o_shift      <= 1'b1;
                        o_crc_update <= 1'b1;
                        // last word has only four body bytes
                        o_crc_nbytes <= pre_last ? 4'(`MAC_WORD_BYTES / 2) :
                                                   4'(`MAC_WORD_BYTES);
                    end
                end
                ST_DONE: begin
                    o_done <= 1'b1;
                    if (accept) begin
                        state   <= ST_PREAMBLE;     // back-to-back frame
                        o_shift <= 1'b1;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
